// File: common/quant_pkg.sv
`default_nettype none

package quant_pkg;

  //////////////////////////////
  // array geometry
  //////////////////////////////

  // columns feeding the quantizer
  localparam int column_num = 4;
  // pixels per column
  localparam int pixel_par = 2;
  // pixels per channel
  localparam int pixel_num = column_num * pixel_par;
  // two channels side by side in the lane array
  localparam int lane_num = 2 * pixel_num;

  //////////////////////////////
  // data widths
  //////////////////////////////

  // 8x8 sum, one channel
  localparam int sum_w_88 = 24;
  // 1x8 sum, two channels
  localparam int sum_w_18 = 16;
  // packed sum vector, 8x24 or 16x16 from bit 0
  localparam int sum_vec_w = lane_num * sum_w_18;
  // channel 1 sums start in the upper half
  localparam int sum_ch1_base = pixel_num * sum_w_18;

  // per-channel scale tail
  localparam int e_w = 16;
  localparam int e_set_w = 2 * e_w;

  // signed A, unsigned B, signed product
  localparam int mult_a_w = 24;
  localparam int mult_b_w = 16;
  localparam int mult_p_w = 40;
  // sign fill when a 1x8 sum goes into an A lane
  localparam int sign_ext_w = mult_a_w - sum_w_18;

  // lane vectors, lane i at bit i * width
  localparam int op_a_vec_w = lane_num * mult_a_w;
  localparam int op_b_vec_w = lane_num * mult_b_w;
  localparam int prod_vec_w = lane_num * mult_p_w;

  // requantize shift
  localparam int shift_w = 6;
  localparam int shift_max = 39;

  // output pixel and clamp range
  localparam int out_w = 8;
  localparam int out_vec_w = lane_num * out_w;
  localparam logic signed [out_w-1:0] out_max = 8'sd127;
  localparam logic signed [out_w-1:0] out_min = -8'sd128;

  //////////////////////////////
  // precision modes
  //////////////////////////////

  localparam int mode_w = 4;
  localparam logic [mode_w-1:0] mode_88 = 4'd0;
  localparam logic [mode_w-1:0] mode_18 = 4'd1;

endpackage

`default_nettype wire

// File: quant/quant_operand_pack.sv
`timescale 1ns/100ps
`default_nettype none

module quant_operand_pack (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                sum_pre,
  input  logic [quant_pkg::sum_vec_w-1:0]     sum_vector,
  input  logic [quant_pkg::e_set_w-1:0]       e_set,
  input  logic [quant_pkg::mode_w-1:0]        mode,
  input  logic [quant_pkg::shift_w-1:0]       shift,
  output logic                                op_valid,
  output logic [quant_pkg::op_a_vec_w-1:0]    op_a,
  output logic [quant_pkg::op_b_vec_w-1:0]    op_b,
  output logic [quant_pkg::shift_w-1:0]       op_shift
);

  // strobe delayed one cycle, data is on the bus now
  logic recv_en;

  // next operand lanes
  logic [quant_pkg::op_a_vec_w-1:0] a_val;
  logic [quant_pkg::op_b_vec_w-1:0] b_val;

  logic is_88;
  logic is_18;

  assign is_88 = (mode == quant_pkg::mode_88);
  assign is_18 = (mode == quant_pkg::mode_18);

  //////////////////////////////
  // lane mapping
  //////////////////////////////

  for (genvar i = 0; i < quant_pkg::pixel_num; i++) begin : g_lane
    logic [quant_pkg::sum_w_88-1:0] sum_88;
    logic [quant_pkg::sum_w_18-1:0] sum_ch0;
    logic [quant_pkg::sum_w_18-1:0] sum_ch1;

    // same pixel index, three views of the vector
    assign sum_88  = sum_vector[i*quant_pkg::sum_w_88 +: quant_pkg::sum_w_88];
    assign sum_ch0 = sum_vector[i*quant_pkg::sum_w_18 +: quant_pkg::sum_w_18];
    assign sum_ch1 = sum_vector[quant_pkg::sum_ch1_base + i*quant_pkg::sum_w_18
                                +: quant_pkg::sum_w_18];

    // channel 0 A lane, 24 bit sum or sign-filled 16 bit sum
    assign a_val[i*quant_pkg::mult_a_w +: quant_pkg::mult_a_w] =
      is_88 ? sum_88 :
      is_18 ? {{quant_pkg::sign_ext_w{sum_ch0[quant_pkg::sum_w_18-1]}}, sum_ch0} :
      '0;

    // channel 1 A lane only live in 1x8
    assign a_val[(quant_pkg::pixel_num + i)*quant_pkg::mult_a_w +: quant_pkg::mult_a_w] =
      is_18 ? {{quant_pkg::sign_ext_w{sum_ch1[quant_pkg::sum_w_18-1]}}, sum_ch1} : '0;

    // low E shared by 8x8 and channel 0, kept even for unused modes
    assign b_val[i*quant_pkg::mult_b_w +: quant_pkg::mult_b_w] = e_set[quant_pkg::e_w-1:0];

    // high E for channel 1
    assign b_val[(quant_pkg::pixel_num + i)*quant_pkg::mult_b_w +: quant_pkg::mult_b_w] =
      is_18 ? e_set[quant_pkg::e_set_w-1:quant_pkg::e_w] : '0;
  end

  //////////////////////////////
  // control pipe
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      recv_en  <= 1'b0;
      op_valid <= 1'b0;
    end else begin
      recv_en  <= sum_pre;
      op_valid <= recv_en;
    end
  end

  // operands held between vectors
  always_ff @(posedge clk) begin
    if (recv_en) begin
      op_a     <= a_val;
      op_b     <= b_val;
      op_shift <= shift;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // modes above 1 only zero the lanes, flag them
  mode_known_a: assert property (@(posedge clk) disable iff (rst)
    recv_en |-> (is_88 || is_18))
    else $warning("quant_operand_pack: unused mode code %0d", mode);

endmodule

`default_nettype wire

// File: quant/quant_mult_array.sv
`timescale 1ns/100ps
`default_nettype none

module quant_mult_array (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                op_valid,
  input  logic [quant_pkg::op_a_vec_w-1:0]    op_a,
  input  logic [quant_pkg::op_b_vec_w-1:0]    op_b,
  input  logic [quant_pkg::shift_w-1:0]       op_shift,
  output logic                                prod_valid,
  output logic [quant_pkg::prod_vec_w-1:0]    prod,
  output logic [quant_pkg::shift_w-1:0]       prod_shift
);

  // all sixteen lane products before the register
  logic [quant_pkg::prod_vec_w-1:0] prod_val;

  //////////////////////////////
  // lane multipliers
  //////////////////////////////

  for (genvar i = 0; i < quant_pkg::lane_num; i++) begin : g_lane
    logic signed [quant_pkg::mult_a_w-1:0] a_lane;
    // E is unsigned, one zero bit on top keeps it positive
    logic signed [quant_pkg::mult_b_w:0]   b_lane;
    logic signed [quant_pkg::mult_p_w-1:0] p_lane;

    assign a_lane = op_a[i*quant_pkg::mult_a_w +: quant_pkg::mult_a_w];
    assign b_lane = {1'b0, op_b[i*quant_pkg::mult_b_w +: quant_pkg::mult_b_w]};

    // 24 x 16 magnitude fits in 40 bits signed
    assign p_lane = a_lane * b_lane;

    assign prod_val[i*quant_pkg::mult_p_w +: quant_pkg::mult_p_w] = p_lane;
  end

  //////////////////////////////
  // product register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= op_valid;
    end
  end

  // shift rides along with its products
  always_ff @(posedge clk) begin
    if (op_valid) begin
      prod       <= prod_val;
      prod_shift <= op_shift;
    end
  end

endmodule

`default_nettype wire

// File: quant/quant_requant.sv
`timescale 1ns/100ps
`default_nettype none

module quant_requant (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                prod_valid,
  input  logic [quant_pkg::prod_vec_w-1:0]    prod,
  input  logic [quant_pkg::shift_w-1:0]       prod_shift,
  output logic                                out_valid,
  output logic [quant_pkg::out_vec_w-1:0]     out_pixels
);

  // one guard bit so the rounding add cannot wrap
  logic signed [quant_pkg::mult_p_w:0] round_half;

  // clamped pixels before the output register
  logic [quant_pkg::out_vec_w-1:0] pixel_val;

  //////////////////////////////
  // rounding step
  //////////////////////////////

  // half of 2^shift, none at shift 0
  assign round_half = (prod_shift == '0) ? '0 :
    ({{quant_pkg::mult_p_w{1'b0}}, 1'b1} << (prod_shift - 1'b1));

  //////////////////////////////
  // per lane shift and clamp
  //////////////////////////////

  for (genvar i = 0; i < quant_pkg::lane_num; i++) begin : g_lane
    logic signed [quant_pkg::mult_p_w-1:0] p_lane;
    logic signed [quant_pkg::mult_p_w:0]   rounded;
    logic signed [quant_pkg::mult_p_w:0]   shifted;
    logic [quant_pkg::out_w-1:0]           sat;

    assign p_lane = prod[i*quant_pkg::mult_p_w +: quant_pkg::mult_p_w];

    // round half up, ties go toward +inf
    assign rounded = p_lane + round_half;

    // arithmetic, keeps the sign
    assign shifted = rounded >>> prod_shift;

    // clamp to int8
    always_comb begin
      if (shifted > quant_pkg::out_max) begin
        sat = quant_pkg::out_max;
      end else if (shifted < quant_pkg::out_min) begin
        sat = quant_pkg::out_min;
      end else begin
        sat = shifted[quant_pkg::out_w-1:0];
      end
    end

    assign pixel_val[i*quant_pkg::out_w +: quant_pkg::out_w] = sat;
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  // one cycle pulse, no back-pressure
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= prod_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      out_pixels <= pixel_val;
    end
  end

  // shifts past the product width are not defined
  shift_range_a: assert property (@(posedge clk) disable iff (rst)
    prod_valid |-> (prod_shift <= quant_pkg::shift_max))
    else $error("quant_requant: shift %0d above limit", prod_shift);

endmodule

`default_nettype wire

// File: rtl/quant_out_top.sv
`timescale 1ns/100ps
`default_nettype none

module quant_out_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                sum_pre,
  input  logic [quant_pkg::sum_vec_w-1:0]     sum_vector,
  input  logic [quant_pkg::e_set_w-1:0]       e_set,
  input  logic [quant_pkg::mode_w-1:0]        mode,
  input  logic [quant_pkg::shift_w-1:0]       shift,
  output logic                                out_valid,
  output logic [quant_pkg::out_vec_w-1:0]     out_pixels
);

  // pack to multiply
  logic                             op_valid;
  logic [quant_pkg::op_a_vec_w-1:0] op_a;
  logic [quant_pkg::op_b_vec_w-1:0] op_b;
  logic [quant_pkg::shift_w-1:0]    op_shift;

  // multiply to requantize
  logic                             prod_valid;
  logic [quant_pkg::prod_vec_w-1:0] prod;
  logic [quant_pkg::shift_w-1:0]    prod_shift;

  // strobe to operands, 2 cycles
  quant_operand_pack i_pack (
    .clk        (clk),
    .rst        (rst),
    .sum_pre    (sum_pre),
    .sum_vector (sum_vector),
    .e_set      (e_set),
    .mode       (mode),
    .shift      (shift),
    .op_valid   (op_valid),
    .op_a       (op_a),
    .op_b       (op_b),
    .op_shift   (op_shift)
  );

  // operands to products, 1 cycle
  quant_mult_array i_mult (
    .clk        (clk),
    .rst        (rst),
    .op_valid   (op_valid),
    .op_a       (op_a),
    .op_b       (op_b),
    .op_shift   (op_shift),
    .prod_valid (prod_valid),
    .prod       (prod),
    .prod_shift (prod_shift)
  );

  // products to int8 pixels, 1 cycle
  quant_requant i_requant (
    .clk        (clk),
    .rst        (rst),
    .prod_valid (prod_valid),
    .prod       (prod),
    .prod_shift (prod_shift),
    .out_valid  (out_valid),
    .out_pixels (out_pixels)
  );

endmodule

`default_nettype wire

// File: test/tb_quant_out.sv
`timescale 1ns/100ps
`default_nettype none

module tb_quant_out;

  // trace path from the project root
  localparam string trace_path = "test/quant_trace.txt";
  // strobe to out_valid, clock cycles
  localparam int latency = 4;
  localparam int rst_cycles = 10;

  logic                              clk;
  logic                              rst;
  logic                              sum_pre;
  logic [quant_pkg::sum_vec_w-1:0]   sum_vector;
  logic [quant_pkg::e_set_w-1:0]     e_set;
  logic [quant_pkg::mode_w-1:0]      mode;
  logic [quant_pkg::shift_w-1:0]     shift;
  logic                              out_valid;
  logic [quant_pkg::out_vec_w-1:0]   out_pixels;

  // trace records, one entry per vector
  int                                rec_test[$];
  logic [quant_pkg::mode_w-1:0]      rec_mode[$];
  logic [quant_pkg::shift_w-1:0]     rec_shift[$];
  logic [quant_pkg::e_set_w-1:0]     rec_e[$];
  logic [quant_pkg::sum_vec_w-1:0]   rec_sum[$];
  logic [quant_pkg::out_vec_w-1:0]   rec_exp[$];

  // vectors in flight, oldest first
  logic [quant_pkg::out_vec_w-1:0]   exp_q[$];
  int                                strobe_q[$];
  int                                test_q[$];

  int cycle_cnt;
  int error_cnt;
  bit trace_loaded;

  quant_out_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .sum_pre    (sum_pre),
    .sum_vector (sum_vector),
    .e_set      (e_set),
    .mode       (mode),
    .shift      (shift),
    .out_valid  (out_valid),
    .out_pixels (out_pixels)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic compare_value(input string name,
                               input logic [quant_pkg::out_vec_w-1:0] expected,
                               input logic [quant_pkg::out_vec_w-1:0] actual);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      error_cnt++;
    end
  endtask

  task automatic load_trace();
    int fd;
    int cnt;
    int t;
    string line;
    logic [quant_pkg::mode_w-1:0]    m;
    logic [quant_pkg::shift_w-1:0]   s;
    logic [quant_pkg::e_set_w-1:0]   e;
    logic [quant_pkg::sum_vec_w-1:0] sv;
    logic [quant_pkg::out_vec_w-1:0] ex;
    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      $display("cannot open trace file %s", trace_path);
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // blank and comment lines
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      cnt = $sscanf(line, "%d %h %d %h %h %h", t, m, s, e, sv, ex);
      if (cnt != 6) begin
        $display("trace line could not be parsed: %s", line);
        error_cnt++;
      end else begin
        rec_test.push_back(t);
        rec_mode.push_back(m);
        rec_shift.push_back(s);
        rec_e.push_back(e);
        rec_sum.push_back(sv);
        rec_exp.push_back(ex);
      end
    end
    $fclose(fd);
  endtask

  // bus contents while no vector is due
  task automatic drive_idle();
    sum_vector = '1;
    e_set      = '1;
    mode       = '1;
    shift      = '1;
  endtask

  task automatic drive_record(input int idx);
    sum_vector = rec_sum[idx];
    e_set      = rec_e[idx];
    mode       = rec_mode[idx];
    shift      = rec_shift[idx];
  endtask

  // back-to-back strobes, data one cycle behind its strobe
  task automatic send_burst(input int first, input int last);
    for (int n = first; n <= last; n++) begin
      @(negedge clk);
      if (n > first) begin
        drive_record(n - 1);
      end else begin
        drive_idle();
      end
      if (n < last) begin
        sum_pre = 1'b1;
        exp_q.push_back(rec_exp[n]);
        strobe_q.push_back(cycle_cnt);
        test_q.push_back(rec_test[n]);
      end else begin
        sum_pre = 1'b0;
      end
    end
    @(negedge clk);
    drive_idle();
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    // late entries get dropped by the monitor
    while (exp_q.size() != 0 && n < 2 * latency) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d vectors still pending after the burst", exp_q.size());
      error_cnt++;
      exp_q.delete();
      strobe_q.delete();
      test_q.delete();
    end
    repeat (2) @(negedge clk);
  endtask

  //////////////////////////////
  // output monitor
  //////////////////////////////

  // samples values settled since the last edge
  always @(posedge clk) begin : monitor
    logic [quant_pkg::out_vec_w-1:0] exp_pixels;
    int strobe_at;
    int test_id;
    if (cycle_cnt > 0) begin
      if (out_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("out_valid pulsed at %0t ns with no vector in flight", $time);
          error_cnt++;
        end else begin
          exp_pixels = exp_q.pop_front();
          strobe_at  = strobe_q.pop_front();
          test_id    = test_q.pop_front();
          compare_value("out_pixels", exp_pixels, out_pixels);
          if (cycle_cnt - strobe_at != latency) begin
            $display("test %0d: result came %0d cycles after its strobe, not %0d",
                     test_id, cycle_cnt - strobe_at, latency);
            error_cnt++;
          end
        end
      end else begin
        // low from reset on and between results
        compare_value("out_valid", '0, out_valid);
        if (exp_q.size() != 0 && cycle_cnt - strobe_q[0] > latency) begin
          $display("test %0d: no result arrived within %0d cycles of the strobe",
                   test_q[0], latency);
          error_cnt++;
          void'(exp_q.pop_front());
          void'(strobe_q.pop_front());
          void'(test_q.pop_front());
        end
      end
    end
    cycle_cnt++;
  end

  //////////////////////////////
  // watchdog
  //////////////////////////////

  initial begin
    wait (trace_loaded);
    repeat (rec_test.size() * 8 + 50) @(posedge clk);
    $display("watchdog expired, the run did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int idx;
    int first;
    int errs_before;
    int test_cnt;
    clk       = 1'b0;
    rst       = 1'b1;
    sum_pre   = 1'b0;
    cycle_cnt = 0;
    error_cnt = 0;
    test_cnt  = 0;
    drive_idle();
    load_trace();
    trace_loaded = 1'b1;
    if (rec_test.size() == 0) begin
      $display("no usable records in %s", trace_path);
      $display("TESTS FAILED");
      $finish;
    end else begin
      repeat (rst_cycles) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      repeat (3) @(negedge clk);
      // one burst per test number
      idx = 0;
      while (idx < rec_test.size()) begin
        first = idx;
        errs_before = error_cnt;
        while (idx < rec_test.size() && rec_test[idx] == rec_test[first]) begin
          idx++;
        end
        send_burst(first, idx);
        wait_drain();
        test_cnt++;
        $display("test %0d done: %0d records, %0d errors",
                 rec_test[first], idx - first, error_cnt - errs_before);
      end
      $display("%0d tests, %0d records, %0d errors", test_cnt, rec_test.size(), error_cnt);
      if (error_cnt == 0) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: test/quant_trace.txt
# columns: test mode shift e_set(hi_e,lo_e) sum_vector(256b hex) expected(16 x int8, lane 15 first)
# test and shift are decimal, the rest hex; records with one test number go out back to back

# test 1: mode 0, signed 24 bit sums, low e only, lanes 8-15 zero, junk above bit 191
1 0 2 12340003 a5a5a5a5a5a5a5a5ffff9c000064ffffff000001ffffd8000028fffff600000a 0000000000000000b54bff01e21ef908
1 0 8 beef00ff 0123456789abcdefffff80000064ffffce000032fffffe000002ffffff000001 00000000000000008164ce32fe02ff01

# test 2: mode 1, channel 1 in the upper 128 bits with the high e, negative 16 bit sums
2 1 1 00020005 ffc00040fff90007fc1803e8ff9c0064ffff0000ffe70019fffd0003fff6000a c040f907807f9c64fe00c23ff908e719
2 1 12 10000300 80000000fffb0005ff7fff800080007f80007ffffc1803e8fff80008fff00010 8000fb0580807f7f807f807fff02fd03

# test 3: half steps round up, clamp at 127 and -128, shift 0 passes the product
3 0 16 00008000 00000000000000008000007ffffffffefeffff00ffff010000ffffff380000c8 0000000000000000807f8080817f9c64
3 0 0 ffff0001 0000000000000000123456ffff7f000080ffff8000007ffffffb000005000000 00000000000000007f807f807ffb0500

# test 4: four vectors in flight, modes mixed
4 0 2 12340003 a5a5a5a5a5a5a5a5ffff9c000064ffffff000001ffffd8000028fffff600000a 0000000000000000b54bff01e21ef908
4 1 1 00020005 ffc00040fff90007fc1803e8ff9c0064ffff0000ffe70019fffd0003fff6000a c040f907807f9c64fe00c23ff908e719
4 0 0 ffff0001 0000000000000000123456ffff7f000080ffff8000007ffffffb000005000000 00000000000000007f807f807ffb0500
4 1 12 10000300 80000000fffb0005ff7fff800080007f80007ffffc1803e8fff80008fff00010 8000fb0580807f7f807f807fff02fd03

# test 5: unused mode 2 zeroes every lane, the next vector is unaffected
5 2 3 12345678 ffc00040fff90007fc1803e8ff9c0064ffff0000ffe70019fffd0003fff6000a 00000000000000000000000000000000
5 1 1 00020005 ffc00040fff90007fc1803e8ff9c0064ffff0000ffe70019fffd0003fff6000a c040f907807f9c64fe00c23ff908e719

// File: filelist.f
common/quant_pkg.sv
quant/quant_operand_pack.sv
quant/quant_mult_array.sv
quant/quant_requant.sv
rtl/quant_out_top.sv
test/tb_quant_out.sv

// File: Makefile
# Verilator build and run for the quantizer output stage

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_quant_out
FILELIST := filelist.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(SIM), run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	rm -f $(LOG)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation log $(LOG) holds the pass line"

clean:
	rm -rf $(BUILD) $(LOG)
